/* all.f */
verilog/fir_pkg.sv
verilog/fir_fold_stage.sv
verilog/fir_const_mult.sv
verilog/fir_mult_bank.sv
verilog/fir_adder_tree.sv
verilog/fir_guide.sv
test/fir_guide_assert.sv
test/fir_guide_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the FIR testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fir_guide_tb \
    -f all.f \
    --Mdir obj_dir \
    -o fir_guide_sim

./obj_dir/fir_guide_sim 2>&1 | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* test/fir_guide_assert.sv */
//**************************************************************************
// concurrent checks on the FIR top-level ports, bound into the DUT
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module fir_guide_assert (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     en,
    input  logic                     valid,
    input  logic [fir_pkg::y_w-1:0]  yout
);

    logic [4:0] since_rst;   // edges since reset release, saturates

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            since_rst <= '0;
        end else if (since_rst != 5'(fir_pkg::fir_latency)) begin
            since_rst <= since_rst + 1'b1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rstn |-> !valid)
        else $error("valid high while reset is active");

    // once the pipeline has filled, valid mirrors en one latency back
    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        (since_rst == 5'(fir_pkg::fir_latency)) |->
            (valid == $past(en, fir_pkg::fir_latency)))
        else $error("valid does not follow en by the pipeline latency");

    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        !valid |-> $stable(yout))
        else $error("yout changed without a valid pulse");

endmodule

bind fir_guide fir_guide_assert u_assert (
    .clk   (clk),
    .rstn  (rstn),
    .en    (en),
    .valid (valid),
    .yout  (yout)
);

`default_nettype wire

/* test/fir_guide_tb.sv */
//**************************************************************************
// FIR front end testbench with stimulus table and reference model
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module fir_guide_tb;

    localparam int tab_len      = 16 + 1 + 20 + 16 + 24 + 40;
    localparam int time_limit   = tab_len + fir_pkg::fir_latency + 40;
    localparam int full_scale_y = 4095 * 2 * 1049;   // 4095 on every tap

    // phase tags of the table
    localparam logic [2:0] ph_lead = 3'd0;
    localparam logic [2:0] ph_imp  = 3'd1;
    localparam logic [2:0] ph_tail = 3'd2;
    localparam logic [2:0] ph_full = 3'd3;
    localparam logic [2:0] ph_gap  = 3'd4;
    localparam logic [2:0] ph_rand = 3'd5;

    typedef struct packed {
        logic                    en;
        logic [fir_pkg::x_w-1:0] x;
        logic [2:0]              phase;
    } stim_t;

    // one result the model expects from the DUT
    typedef struct packed {
        logic [63:0] y;
        logic [31:0] due;     // edge at which valid is sampled high
        logic [2:0]  phase;
        logic        full;    // history held only full-scale samples
    } expect_t;

    logic                    clk;
    logic                    rstn;
    logic                    en;
    logic [fir_pkg::x_w-1:0] xin;
    logic                    valid;
    logic [fir_pkg::y_w-1:0] yout;

    stim_t      tab [tab_len];
    logic [2:0] cur_phase;        // tag of the entry now on en and xin
    int         cycle;
    longint     last_y;
    longint     hist [16];        // model history with newest at 0
    expect_t    exp_q [$];

    fir_guide u_dut (
        .clk   (clk),
        .rstn  (rstn),
        .en    (en),
        .xin   (xin),
        .valid (valid),
        .yout  (yout)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check(input longint got, input longint want, input string what);
        if (got != want) begin
            $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, what, got, want);
            $display(">>> FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic void put_entry(input int idx, input logic e,
                                      input logic [fir_pkg::x_w-1:0] x,
                                      input logic [2:0] ph);
        tab[idx] = '{en: e, x: x, phase: ph};
    endfunction

    task automatic build_table();
        int idx;
        idx = 0;
        for (int i = 0; i < 16; i++) begin
            put_entry(idx, 1'b1, '0, ph_lead);
            idx++;
        end
        put_entry(idx, 1'b1, 12'd1, ph_imp);   // single unit impulse
        idx++;
        for (int i = 0; i < 20; i++) begin
            put_entry(idx, 1'b1, '0, ph_tail);
            idx++;
        end
        for (int i = 0; i < 16; i++) begin
            put_entry(idx, 1'b1, 12'hfff, ph_full);
            idx++;
        end
        for (int i = 0; i < 24; i++) begin
            put_entry(idx, (i % 3) != 1, 12'($urandom), ph_gap);   // xin still moves
            idx++;
        end
        for (int i = 0; i < 40; i++) begin
            put_entry(idx, 1'b1, 12'($urandom), ph_rand);
            idx++;
        end
    endtask

    // sum over pairs of coefficient times mirrored tap sum
    function automatic longint model_y();
        longint acc;
        acc = 0;
        for (int k = 0; k < 8; k++) begin
            acc += longint'(fir_pkg::coef_tab[k]) * (hist[k] + hist[15-k]);
        end
        return acc;
    endfunction

    // monitor and reference model reading values from before this edge
    always @(posedge clk) begin
        expect_t head;
        expect_t nxt;
        logic    all_full;
        cycle = cycle + 1;
        if (cycle >= time_limit) begin
            $display("ERROR: timeout after %0d cycles, results still outstanding", cycle);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
        if (!rstn) begin
            check(valid, 0, "valid during reset");
            check(yout, 0, "yout during reset");
        end else if (valid) begin
            check(exp_q.size() > 0, 1, "valid pulse with no sample pending");
            head = exp_q.pop_front();
            check(cycle, head.due, $sformatf("valid timing, phase %0d", head.phase));
            check(yout, head.y, $sformatf("yout value, phase %0d", head.phase));
            if (head.full) begin
                check(yout, full_scale_y, "full-scale output");
            end
        end else begin
            if (exp_q.size() > 0) begin
                check(exp_q[0].due > cycle, 1, "valid pulse missing");
            end
            check(yout, last_y, "yout hold while valid low");
        end
        last_y = yout;
        if (rstn && en) begin
            for (int k = 15; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            hist[0]  = xin;
            all_full = 1'b1;
            for (int k = 0; k < 16; k++) begin
                all_full &= (hist[k] == 4095);
            end
            nxt.y     = model_y();
            nxt.due   = cycle + fir_pkg::fir_latency;
            nxt.phase = cur_phase;
            nxt.full  = all_full;
            exp_q.push_back(nxt);
        end
    end

    initial begin
        void'($urandom(32'h5bca477d));
        rstn      = 1'b0;
        en        = 1'b0;
        xin       = '0;
        cur_phase = '0;
        cycle     = 0;
        last_y    = 0;
        for (int k = 0; k < 16; k++) begin
            hist[k] = 0;
        end
        build_table();

        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        foreach (tab[i]) begin
            @(posedge clk);
            en        <= tab[i].en;
            xin       <= tab[i].x;
            cur_phase <= tab[i].phase;
        end
        @(posedge clk);
        en  <= 1'b0;
        xin <= '0;

        @(posedge clk);
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // no stray pulses after the drain

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/fir_adder_tree.sv */
//**************************************************************************
// two-level registered sum of the eight products
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module fir_adder_tree (
    input  logic                     clk,
    input  logic                     rstn,
    input  fir_pkg::prod_t           prod,
    output logic                     valid,
    output logic [fir_pkg::y_w-1:0]  yout
);

    logic [fir_pkg::y_w-1:0] sum_lo;   // products 0..3
    logic [fir_pkg::y_w-1:0] sum_hi;   // products 4..7
    logic                    sum_valid;

    // first level, two groups of four
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sum_lo    <= '0;
            sum_hi    <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod.valid;
            if (prod.valid) begin
                sum_lo <= prod.prod[0] + prod.prod[1] + prod.prod[2] + prod.prod[3];
                sum_hi <= prod.prod[4] + prod.prod[5] + prod.prod[6] + prod.prod[7];
            end
        end
    end

    // second level, yout holds between results
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            yout  <= '0;
            valid <= 1'b0;
        end else begin
            valid <= sum_valid;
            if (sum_valid) begin
                yout <= sum_lo + sum_hi;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fir_const_mult.sv */
//**************************************************************************
// pipelined shift-add multiplier by a constant coefficient
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module fir_const_mult #(
    parameter int             a_w  = 13,
    parameter int             c_w  = 12,
    parameter logic [c_w-1:0] coef = '0
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               data_rdy,
    input  logic [a_w-1:0]     mult1,
    output logic               res_rdy,
    output logic [a_w+c_w-1:0] res
);

    // one register stage per coefficient bit
    logic [c_w-1:0]     rdy_q;
    logic [a_w-1:0]     opnd_q [c_w-1];   // last stage needs no operand
    logic [a_w+c_w-1:0] acc_q  [c_w];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdy_q <= '0;
            for (int i = 0; i < c_w - 1; i++) begin
                opnd_q[i] <= '0;
            end
            for (int i = 0; i < c_w; i++) begin
                acc_q[i] <= '0;
            end
        end else begin
            // stage 0 takes bit 0 straight from the input
            rdy_q[0]  <= data_rdy;
            opnd_q[0] <= mult1;
            if (coef[0]) begin
                acc_q[0] <= (a_w+c_w)'(mult1);
            end else begin
                acc_q[0] <= '0;
            end

            for (int i = 1; i < c_w; i++) begin
                rdy_q[i] <= rdy_q[i-1];
                // partial product only where the coefficient has a one
                if (coef[i]) begin
                    acc_q[i] <= acc_q[i-1] + ((a_w+c_w)'(opnd_q[i-1]) << i);
                end else begin
                    acc_q[i] <= acc_q[i-1];
                end
            end

            for (int i = 1; i < c_w - 1; i++) begin
                opnd_q[i] <= opnd_q[i-1];   // operand rides along
            end
        end
    end

    assign res_rdy = rdy_q[c_w-1];
    assign res     = acc_q[c_w-1];

endmodule

`default_nettype wire

/* verilog/fir_fold_stage.sv */
//**************************************************************************
// 16-tap delay line and registered symmetric pre-adders
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module fir_fold_stage (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     en,
    input  logic [fir_pkg::x_w-1:0]  xin,
    output fir_pkg::fold_t           fold
);

    // tap 0 is the newest sample
    logic [fir_pkg::n_taps-1:0][fir_pkg::x_w-1:0] taps;
    logic                                         en_q;   // marks a fresh shift

    // delay line, all taps cleared on reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            taps <= '0;
            en_q <= 1'b0;
        end else begin
            en_q <= en;
            if (en) begin
                taps <= {taps[fir_pkg::n_taps-2:0], xin};
            end
        end
    end

    // pair k folds tap k with its mirror tap
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fold <= '0;
        end else begin
            fold.valid <= en_q;
            if (en_q) begin
                for (int k = 0; k < fir_pkg::n_fold; k++) begin
                    fold.sum[k] <= taps[k] + taps[fir_pkg::n_taps-1-k];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fir_guide.sv */
//**************************************************************************
// top level of the symmetric 16-tap FIR front end
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module fir_guide (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     en,     // sample strobe
    input  logic [fir_pkg::x_w-1:0]  xin,
    output logic                     valid,  // one pulse per result
    output logic [fir_pkg::y_w-1:0]  yout
);

    fir_pkg::fold_t fold;   // pair sums, 2 cycles after accept
    fir_pkg::prod_t prod;   // products, 12 cycles later

    fir_fold_stage u_fold (
        .clk  (clk),
        .rstn (rstn),
        .en   (en),
        .xin  (xin),
        .fold (fold)
    );

    fir_mult_bank u_mult (
        .clk  (clk),
        .rstn (rstn),
        .fold (fold),
        .prod (prod)
    );

    // last two cycles of the 16-cycle latency
    fir_adder_tree u_tree (
        .clk   (clk),
        .rstn  (rstn),
        .prod  (prod),
        .valid (valid),
        .yout  (yout)
    );

endmodule

`default_nettype wire

/* verilog/fir_mult_bank.sv */
//**************************************************************************
// eight constant multipliers, one per folded tap pair
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module fir_mult_bank (
    input  logic            clk,
    input  logic            rstn,
    input  fir_pkg::fold_t  fold,
    output fir_pkg::prod_t  prod
);

    wire [fir_pkg::n_fold-1:0][fir_pkg::prod_w-1:0] res;
    wire                                            res_valid;

    for (genvar k = 0; k < fir_pkg::n_fold; k++) begin : g_mult
        if (k == 0) begin : g_lead
            // all lanes share one timing, lane 0 supplies the valid
            fir_const_mult #(
                .a_w  (fir_pkg::fold_w),
                .c_w  (fir_pkg::coef_w),
                .coef (fir_pkg::coef_tab[k])
            ) u_mult (
                .clk      (clk),
                .rstn     (rstn),
                .data_rdy (fold.valid),
                .mult1    (fold.sum[k]),
                .res_rdy  (res_valid),
                .res      (res[k])
            );
        end else begin : g_lane
            fir_const_mult #(
                .a_w  (fir_pkg::fold_w),
                .c_w  (fir_pkg::coef_w),
                .coef (fir_pkg::coef_tab[k])
            ) u_mult (
                .clk      (clk),
                .rstn     (rstn),
                .data_rdy (fold.valid),
                .mult1    (fold.sum[k]),
                .res_rdy  (),
                .res      (res[k])
            );
        end
    end

    assign prod = fir_pkg::prod_t'{valid: res_valid, prod: res};

endmodule

`default_nettype wire

/* verilog/fir_pkg.sv */
//**************************************************************************
// shared widths, coefficient table, latency and stage structs of the FIR
//**************************************************************************
`default_nettype none

package fir_pkg;

    localparam int x_w    = 12;            // input sample
    localparam int n_taps = 16;
    localparam int n_fold = n_taps / 2;    // mirrored tap pairs
    localparam int fold_w = x_w + 1;       // pair sum
    localparam int coef_w = 12;            // also the multiplier depth
    localparam int prod_w = fold_w + coef_w;
    localparam int y_w    = prod_w + 4;    // guard bits for 8 products

    // outer pair first, centre pair last; index 0 holds 11
    localparam logic [n_fold-1:0][coef_w-1:0] coef_tab = {
        12'd255,
        12'd235,
        12'd198,
        12'd152,
        12'd104,
        12'd63,
        12'd31,
        12'd11
    };

    // delay line + pre-add + multiplier + adder tree
    localparam int fir_latency = 1 + 1 + coef_w + 2;

    // folded pair sums with their valid bit
    typedef struct packed {
        logic                          valid;
        logic [n_fold-1:0][fold_w-1:0] sum;
    } fold_t;

    // products of the folded sums, one per coefficient
    typedef struct packed {
        logic                          valid;
        logic [n_fold-1:0][prod_w-1:0] prod;
    } prod_t;

endpackage

`default_nettype wire
